// ==== logic/rv_isa_pkg.sv ====
/*
  RV32I encodings for the register and immediate arithmetic subset,
  plus the internal ALU operation code passed from decode to execute
*/
package rv_isa_pkg;

    // Major opcodes of the supported instruction classes
    typedef enum logic [6:0] {
        OP_REG = 7'b0110011,  // R-type arithmetic
        OP_IMM = 7'b0010011,  // Register-immediate arithmetic
        OP_LUI = 7'b0110111
    } opcode_t;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000;  // Selects SUB and SRA

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // LUI, operand B straight through
    } alu_op_t;

endpackage

// ==== logic/core_cfg_pkg.sv ====
/*
  Sizes of this core: data width, register file and instruction memory
  depth, with the matching index and word types
*/
package core_cfg_pkg;

    localparam int XLEN        = 32;              // Data and PC width
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 2 ** REG_ADDR_W;
    localparam int IMEM_ADDR_W = 8;               // Word address bits
    localparam int IMEM_DEPTH  = 2 ** IMEM_ADDR_W;

    typedef logic [XLEN-1:0]        word_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;

    // Byte step between consecutive instructions
    localparam word_t PC_STEP = 4;

endpackage

// ==== logic/pipe_ifs.sv ====
/*
  Bundles between the decode stage and the execute unit. The decoder
  fills decode_if and the register read side fills operand_if
*/
`timescale 1ns/1ps

interface decode_if;
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    alu_op_t   alu_op;
    logic      use_imm;    // B operand comes from imm
    word_t     imm;
    reg_addr_t rd;
    logic      reg_write;  // Already qualified with valid and rd != 0
    logic      valid;

    modport dec (output alu_op, use_imm, imm, rd, reg_write, valid);
    modport exe (input alu_op, use_imm, imm, rd, reg_write, valid);
endinterface

interface operand_if;
    import core_cfg_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;

    modport rd  (output rs1, rs2, rs1_data, rs2_data);
    modport exe (input rs1, rs2, rs1_data, rs2_data);
endinterface

// ==== logic/fetch_unit.sv ====
/*
  Instruction fetch. Holds the PC and the word-wide instruction memory,
  which is loaded through the write port while the core is stopped.
  The synchronous memory read lands in the fetch/decode register
*/
`timescale 1ns/1ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_en,
    input  logic                     i_imem_wen,
    input  core_cfg_pkg::imem_addr_t i_imem_waddr,
    input  core_cfg_pkg::word_t      i_imem_wdata,
    output core_cfg_pkg::word_t      o_pc,
    output core_cfg_pkg::word_t      o_instr,
    output logic                     o_instr_valid
);
    import core_cfg_pkg::*;

    word_t      pc;
    imem_addr_t pc_word;   // Word index into the memory
    word_t      imem [IMEM_DEPTH];
    word_t      fd_instr;  // Fetch/decode register
    logic       fd_valid;

    assign pc_word = pc[IMEM_ADDR_W+1:2];

    // PC and valid bit
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc       <= '0;
            fd_valid <= 1'b0;
        end else if (i_en) begin
            pc       <= pc + PC_STEP;
            fd_valid <= 1'b1;  // First fetched word arrives here
        end
    end

    // Load port, one word per strobe
    always_ff @(posedge clk) begin
        if (i_imem_wen) begin
            imem[i_imem_waddr] <= i_imem_wdata;
        end
    end

    // Synchronous read straight into the fetch/decode register
    always_ff @(posedge clk) begin
        if (i_en) begin
            fd_instr <= imem[pc_word];
        end
    end

    assign o_pc          = pc;
    assign o_instr       = fd_instr;
    assign o_instr_valid = fd_valid;

endmodule

// ==== logic/inst_decoder.sv ====
/*
  Combinational decode of the fetched word into ALU operation,
  immediate and write-back control. Unsupported opcodes decode to a
  no-op with register write off
*/
`timescale 1ns/1ps

module inst_decoder (
    input  core_cfg_pkg::word_t i_instr,
    input  logic                i_instr_valid,
    decode_if.dec               o_dec
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    logic       kept_op;    // Opcode is one of the supported classes
    alu_op_t    arith_op;   // Shared funct3/funct7 decode
    word_t      imm_i;
    word_t      imm_shamt;
    word_t      imm_u;

    assign opcode = i_instr[6:0];
    assign rd     = i_instr[11:7];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    // Immediate forms
    assign imm_i     = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign imm_shamt = {{(XLEN-5){1'b0}}, i_instr[24:20]};
    assign imm_u     = {i_instr[31:12], 12'b0};

    always_comb begin
        case (funct3)
            F3_ADD_SUB: begin
                // Only the register form has SUB
                if (opcode == OP_REG && funct7 == F7_ALT) begin
                    arith_op = ALU_SUB;
                end else begin
                    arith_op = ALU_ADD;
                end
            end
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SRL_SRA: arith_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            F3_AND:     arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        kept_op       = 1'b0;
        o_dec.alu_op  = arith_op;
        o_dec.use_imm = 1'b0;
        o_dec.imm     = imm_i;
        case (opcode)
            OP_REG: kept_op = 1'b1;
            OP_IMM: begin
                kept_op       = 1'b1;
                o_dec.use_imm = 1'b1;
                if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
                    o_dec.imm = imm_shamt;  // SLLI/SRLI/SRAI
                end
            end
            OP_LUI: begin
                kept_op       = 1'b1;
                o_dec.alu_op  = ALU_PASS_B;
                o_dec.use_imm = 1'b1;
                o_dec.imm     = imm_u;
            end
            default: o_dec.alu_op = ALU_ADD;  // No-op
        endcase
    end

    assign o_dec.rd        = rd;
    assign o_dec.valid     = i_instr_valid;
    assign o_dec.reg_write = kept_op && i_instr_valid && (rd != '0);

endmodule

// ==== logic/operand_reader.sv ====
/*
  Register file with two instruction read ports and a debug read port.
  A write-back to the register being read in the same cycle is passed
  through to the read port. x0 always reads zero
*/
`timescale 1ns/1ps

module operand_reader (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_en,
    input  core_cfg_pkg::word_t     i_instr,
    input  logic                    i_wb_en,
    input  core_cfg_pkg::reg_addr_t i_wb_rd,
    input  core_cfg_pkg::word_t     i_wb_data,
    input  core_cfg_pkg::reg_addr_t i_dbg_addr,
    output core_cfg_pkg::word_t     o_dbg_data,
    operand_if.rd                   o_opd
);
    import core_cfg_pkg::*;

    word_t     regs [NUM_REGS];
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      wb_hit_rs1;
    logic      wb_hit_rs2;

    assign rs1 = i_instr[19:15];
    assign rs2 = i_instr[24:20];

    // Write-back landing this cycle on a register being read
    assign wb_hit_rs1 = i_wb_en && (i_wb_rd == rs1);
    assign wb_hit_rs2 = i_wb_en && (i_wb_rd == rs2);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_en && i_wb_en && i_wb_rd != '0) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    always_comb begin
        if (rs1 == '0) begin
            o_opd.rs1_data = '0;
        end else if (wb_hit_rs1) begin
            o_opd.rs1_data = i_wb_data;
        end else begin
            o_opd.rs1_data = regs[rs1];
        end

        if (rs2 == '0) begin
            o_opd.rs2_data = '0;
        end else if (wb_hit_rs2) begin
            o_opd.rs2_data = i_wb_data;
        end else begin
            o_opd.rs2_data = regs[rs2];
        end
    end

    assign o_opd.rs1 = rs1;
    assign o_opd.rs2 = rs2;

    // Debug port sees only stored values
    assign o_dbg_data = (i_dbg_addr == '0) ? '0 : regs[i_dbg_addr];

endmodule

// ==== logic/execute_unit.sv ====
/*
  Execute stage. Captures decode and operands in the decode/execute
  register, forwards the previous result when needed, runs the ALU and
  holds the result in the execute/write-back register
*/
`timescale 1ns/1ps

module execute_unit (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_en,
    decode_if.exe                   i_dec,
    operand_if.exe                  i_opd,
    output logic                    o_wb_en,
    output core_cfg_pkg::reg_addr_t o_wb_rd,
    output core_cfg_pkg::word_t     o_wb_data
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    // Decode/execute register
    logic      de_valid;
    logic      de_reg_write;
    alu_op_t   de_alu_op;
    logic      de_use_imm;
    word_t     de_imm;
    reg_addr_t de_rd;
    reg_addr_t de_rs1;
    reg_addr_t de_rs2;
    word_t     de_rs1_data;
    word_t     de_rs2_data;

    // Execute/write-back register
    logic      ew_wb_en;
    reg_addr_t ew_rd;
    word_t     ew_data;

    word_t      op_a;
    word_t      op_b_reg;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu_result;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            de_valid     <= 1'b0;
            de_reg_write <= 1'b0;
            ew_wb_en     <= 1'b0;
        end else if (i_en) begin
            de_valid     <= i_dec.valid;
            de_reg_write <= i_dec.reg_write;
            ew_wb_en     <= de_valid && de_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            de_alu_op   <= i_dec.alu_op;
            de_use_imm  <= i_dec.use_imm;
            de_imm      <= i_dec.imm;
            de_rd       <= i_dec.rd;
            de_rs1      <= i_opd.rs1;
            de_rs2      <= i_opd.rs2;
            de_rs1_data <= i_opd.rs1_data;
            de_rs2_data <= i_opd.rs2_data;
            ew_rd       <= de_rd;
            ew_data     <= alu_result;
        end
    end

    // Forward from the instruction one ahead
    assign op_a = (ew_wb_en && ew_rd != '0 && ew_rd == de_rs1) ? ew_data : de_rs1_data;
    assign op_b_reg = (ew_wb_en && ew_rd != '0 && ew_rd == de_rs2) ? ew_data : de_rs2_data;
    assign op_b  = de_use_imm ? de_imm : op_b_reg;
    assign shamt = op_b[4:0];

    always_comb begin
        case (de_alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    assign o_wb_en   = ew_wb_en;
    assign o_wb_rd   = ew_rd;
    assign o_wb_data = ew_data;

endmodule

// ==== logic/alu_core.sv ====
/*
  Top of the four-stage RV32I arithmetic pipeline. Load the program
  through the memory write port with i_en low, then raise i_en to run.
  The debug port reads the register file at any time
*/
`timescale 1ns/1ps

module alu_core (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_en,
    input  logic                     i_imem_wen,
    input  core_cfg_pkg::imem_addr_t i_imem_waddr,
    input  core_cfg_pkg::word_t      i_imem_wdata,
    input  core_cfg_pkg::reg_addr_t  i_dbg_addr,
    output core_cfg_pkg::word_t      o_pc,
    output core_cfg_pkg::word_t      o_instr,
    output core_cfg_pkg::word_t      o_dbg_data
);
    import core_cfg_pkg::*;

    logic      instr_valid;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    decode_if  dec_bus ();
    operand_if opd_bus ();

    fetch_unit u_fetch (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_en          (i_en),
        .i_imem_wen    (i_imem_wen),
        .i_imem_waddr  (i_imem_waddr),
        .i_imem_wdata  (i_imem_wdata),
        .o_pc          (o_pc),
        .o_instr       (o_instr),      // Also feeds both decode-side units
        .o_instr_valid (instr_valid)
    );

    inst_decoder u_decoder (
        .i_instr       (o_instr),
        .i_instr_valid (instr_valid),
        .o_dec         (dec_bus.dec)
    );

    operand_reader u_operands (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_en       (i_en),
        .i_instr    (o_instr),
        .i_wb_en    (wb_en),
        .i_wb_rd    (wb_rd),
        .i_wb_data  (wb_data),
        .i_dbg_addr (i_dbg_addr),
        .o_dbg_data (o_dbg_data),
        .o_opd      (opd_bus.rd)
    );

    execute_unit u_execute (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_en      (i_en),
        .i_dec     (dec_bus.exe),
        .i_opd     (opd_bus.exe),
        .o_wb_en   (wb_en),
        .o_wb_rd   (wb_rd),
        .o_wb_data (wb_data)
    );

endmodule

// ==== testbench/tb_alu_core_sva.sv ====
/*
  PC and run enable assertions, bound into the core top level
*/
`timescale 1ns/1ps

module tb_alu_core_sva (
    input logic                clk,
    input logic                i_rst,
    input logic                i_en,
    input core_cfg_pkg::word_t o_pc
);

    a_reset_pc : assert property (@(posedge clk) i_rst |=> o_pc == '0)
        else $error("PC not zero after reset");

    // Stopped core keeps its PC
    a_pc_hold : assert property (@(posedge clk) !i_rst && !i_en |=> o_pc == $past(o_pc))
        else $error("PC moved while the core was stopped");

    a_pc_step : assert property (@(posedge clk) !i_rst && i_en |=> o_pc == $past(o_pc) + 32'd4)
        else $error("PC did not advance by one word");

endmodule

bind alu_core tb_alu_core_sva u_sva (
    .clk   (clk),
    .i_rst (i_rst),
    .i_en  (i_en),
    .o_pc  (o_pc)
);

// ==== testbench/tb_alu_core.sv ====
/*
  Testbench for the arithmetic pipeline. Builds random programs, runs them
  through the memory load port and compares the register file, read over
  the debug port, with a reference interpreter
*/
`timescale 1ns/1ps

module tb_alu_core;
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    localparam int NUM_TESTS = 5;

    logic       clk;
    logic       i_rst;
    logic       i_en;
    logic       i_imem_wen;
    imem_addr_t i_imem_waddr;
    word_t      i_imem_wdata;
    reg_addr_t  i_dbg_addr;
    word_t      o_pc;
    word_t      o_instr;
    word_t      o_dbg_data;

    integer seed = 32'h6df3;
    word_t  prog [$];         // Program of the current test
    string  cur_name;
    int     req_count = 0;    // Programs handed to the comparison
    int     done_count = 0;
    int     err_count = 0;
    int     timeout_count = 0;
    logic   aborted = 1'b0;

    alu_core uut (
        .clk(clk), .i_rst(i_rst), .i_en(i_en), .i_imem_wen(i_imem_wen),
        .i_imem_waddr(i_imem_waddr), .i_imem_wdata(i_imem_wdata), .i_dbg_addr(i_dbg_addr),
        .o_pc(o_pc), .o_instr(o_instr), .o_dbg_data(o_dbg_data)
    );

    always #2 clk = ~clk;

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic word_t enc_lui(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($unsigned($random(seed)) % 32);
    endfunction

    // SUB and SRA only for the funct3 values that have an alternate form
    function automatic logic [6:0] rand_f7(logic [2:0] f3);
        if ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && $random(seed) % 2 == 0) return F7_ALT;
        return 7'b0;
    endfunction

    function automatic logic [11:0] rand_imm(logic [2:0] f3);
        word_t r;
        r = $random(seed);
        if (f3 == F3_SLL) return {7'b0, r[4:0]};
        if (f3 == F3_SRL_SRA) return {r[8] ? F7_ALT : 7'b0, r[4:0]};
        return r[11:0];
    endfunction

    function automatic logic ref_writes(word_t instr);
        logic [6:0] op;
        op = instr[6:0];
        return (op == OP_REG || op == OP_IMM || op == OP_LUI) && instr[11:7] != 5'd0;
    endfunction

    // Expected rd value from the RV32I rules; a is rs1, b is rs2
    function automatic word_t ref_result(word_t instr, word_t a, word_t b);
        logic [2:0] f3;
        logic       alt;
        word_t      imm;
        f3  = instr[14:12];
        alt = instr[31:25] == F7_ALT;
        imm = {{20{instr[31]}}, instr[31:20]};
        if (instr[6:0] == OP_LUI) return {instr[31:12], 12'b0};
        if (instr[6:0] == OP_IMM) begin
            if (f3 == F3_ADD_SUB) return a + imm;
            if (f3 == F3_SLL || f3 == F3_SRL_SRA) b = word_t'(instr[24:20]);
            else b = imm;
        end else if (f3 == F3_ADD_SUB) begin
            return alt ? a - b : a + b;
        end
        case (f3)
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return word_t'($signed(a) < $signed(b));
            F3_SLTU:    return word_t'(a < b);
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    task automatic check_value(string what, word_t exp, word_t act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", what, exp, act);
            err_count++;
        end
    endtask

    // Random values in x1..x31 through LUI + ADDI pairs
    task automatic add_init();
        word_t v;
        for (int r = 1; r < NUM_REGS; r++) begin
            v = $random(seed);
            prog.push_back(enc_lui(v[31:12], reg_addr_t'(r)));
            prog.push_back(enc_i(v[11:0], reg_addr_t'(r), F3_ADD_SUB, reg_addr_t'(r)));
        end
    endtask

    task automatic run_program(string name);
        int    n;
        int    waited;
        if (aborted) return;
        cur_name = name;
        n = prog.size() + 8;
        for (int i = 0; i < n; i++) begin  // Zero tail decodes as no-ops
            @(posedge clk);
            #1;
            i_imem_wen   = 1'b1;
            i_imem_waddr = imem_addr_t'(i);
            i_imem_wdata = (i < prog.size()) ? prog[i] : word_t'(0);
        end
        @(posedge clk);
        #1;
        i_imem_wen = 1'b0;
        i_rst      = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        i_rst = 1'b0;
        check_value({name, " reset pc"}, word_t'(0), o_pc);
        i_en = 1'b1;
        for (int c = 1; c <= n; c++) begin
            @(posedge clk);
            #1;
            check_value({name, " pc"}, word_t'(4 * c), o_pc);
            check_value({name, " instr"}, (c - 1 < prog.size()) ? prog[c-1] : word_t'(0),
                        o_instr);
        end
        i_en = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_value({name, " pc hold"}, word_t'(4 * n), o_pc);
        end
        req_count++;
        waited = 0;
        while (done_count != req_count && waited < 200 && !aborted) begin
            @(posedge clk);
            waited++;
        end
        if (done_count != req_count) begin
            $display("ERROR: register comparison for %s did not finish in time", name);
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    // Comparison process, one pass per program
    initial begin : compare_proc
        word_t     ref_regs [NUM_REGS];
        int        waited;
        reg_addr_t rd;
        for (int t = 0; t < NUM_TESTS; t++) begin
            waited = 0;
            while (req_count == done_count && waited < 2000 && !aborted) begin
                @(posedge clk);
                waited++;
            end
            if (req_count == done_count) begin
                $display("ERROR: no program arrived for comparison %0d", t);
                timeout_count++;
                aborted = 1'b1;
                break;
            end
            foreach (ref_regs[i]) ref_regs[i] = '0;
            foreach (prog[k]) begin
                rd = prog[k][11:7];
                if (ref_writes(prog[k])) begin
                    ref_regs[rd] = ref_result(prog[k], ref_regs[prog[k][19:15]],
                                              ref_regs[prog[k][24:20]]);
                end
            end
            for (int r = 0; r < NUM_REGS; r++) begin
                @(posedge clk);
                #1;
                i_dbg_addr = reg_addr_t'(r);
                #1;
                check_value($sformatf("%s x%0d", cur_name, r), ref_regs[r], o_dbg_data);
            end
            done_count++;
        end
    end

    initial begin
        logic [2:0] f3;
        reg_addr_t  rd;
        reg_addr_t  prev1;
        reg_addr_t  prev2;
        word_t      w;
        logic [11:0] bounds [5];
        clk = 1'b0;
        i_rst = 1'b1;
        i_en = 1'b0;
        i_imem_wen = 1'b0;
        i_imem_waddr = '0;
        i_imem_wdata = '0;
        i_dbg_addr = '0;
        bounds = '{12'h7ff, 12'h800, 12'hfff, 12'h000, 12'h001};
        repeat (3) @(posedge clk);
        #1;
        i_rst = 1'b0;

        prog.delete();
        add_init();
        repeat (50) begin
            f3 = 3'($random(seed));
            prog.push_back(enc_r(rand_f7(f3), rand_reg(), rand_reg(), f3, rand_reg()));
        end
        run_program("r_type");

        prog.delete();
        add_init();
        prog.push_back(enc_lui(20'h80000, 5'd5));              // x5 = 0x80000000
        prog.push_back(enc_lui(20'h80000, 5'd6));
        prog.push_back(enc_i(12'hfff, 5'd6, F3_ADD_SUB, 5'd6)); // x6 = 0x7fffffff
        prog.push_back(enc_i(12'hfff, 5'd0, F3_ADD_SUB, 5'd7)); // x7 = all ones
        foreach (bounds[b]) begin
            for (int s = 4; s < 8; s++) begin
                rd = reg_addr_t'(8 + $unsigned($random(seed)) % 24);
                prog.push_back(enc_i(bounds[b], reg_addr_t'(s % 8), F3_SLT, rd));
                rd = reg_addr_t'(8 + $unsigned($random(seed)) % 24);
                prog.push_back(enc_i(bounds[b], reg_addr_t'(s % 8), F3_SLTU, rd));
            end
        end
        prog.push_back(enc_i(12'd31, 5'd7, F3_SLL, 5'd9));
        prog.push_back(enc_i(12'd4, 5'd5, F3_SRL_SRA, 5'd10));
        prog.push_back(enc_i({F7_ALT, 5'd4}, 5'd5, F3_SRL_SRA, 5'd11));
        repeat (30) begin
            f3 = 3'($random(seed));
            if ($random(seed) % 4 == 0) prog.push_back(enc_lui(20'($random(seed)), rand_reg()));
            else prog.push_back(enc_i(rand_imm(f3), rand_reg(), f3, rand_reg()));
        end
        run_program("i_type");

        prog.delete();
        add_init();
        prev1 = 5'd1;
        prev2 = 5'd2;
        repeat (40) begin
            f3 = 3'($random(seed));
            rd = reg_addr_t'(1 + $unsigned($random(seed)) % 31);
            if ($random(seed) % 2 == 0) prog.push_back(enc_r(rand_f7(f3), prev2, prev1, f3, rd));
            else prog.push_back(enc_i(rand_imm(f3), prev1, f3, rd));
            prev2 = prev1;
            prev1 = rd;
        end
        run_program("chain");

        prog.delete();
        add_init();
        repeat (30) begin
            f3 = 3'($random(seed));
            w  = $random(seed);
            case ($unsigned($random(seed)) % 4)
                0: prog.push_back(enc_r(rand_f7(f3), rand_reg(), rand_reg(), f3, 5'd0));
                1: prog.push_back(enc_i(rand_imm(f3), rand_reg(), f3, 5'd0));
                2: prog.push_back(enc_lui(w[19:0], 5'd0));
                default: begin
                    if (w[6:0] == OP_REG || w[6:0] == OP_IMM || w[6:0] == OP_LUI) begin
                        w[6:0] = 7'b1100011;  // Branch opcode, not supported
                    end
                    prog.push_back(w);
                end
            endcase
        end
        run_program("x0_and_unsupported");

        // Registers still hold the last program's values until this reset
        prog.delete();
        run_program("reset");

        $display("Errors: %0d failed checks, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
logic/rv_isa_pkg.sv
logic/core_cfg_pkg.sv
logic/pipe_ifs.sv
logic/fetch_unit.sv
logic/inst_decoder.sv
logic/operand_reader.sv
logic/execute_unit.sv
logic/alu_core.sv
testbench/tb_alu_core_sva.sv
testbench/tb_alu_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile with Verilator and run; pass only if the pass line appears
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --top-module tb_alu_core -f build.f -o sim_alu_core || exit 1
out="$(./obj_dir/sim_alu_core)"
echo "$out"
echo "$out" | grep -qx "TEST PASS" && exit 0 || exit 1
